// File: hw/core_pkg.sv
package core_pkg;

    // **************************************************
    // memory operations
    // **************************************************

    // MEM_X means the instruction does not touch memory
    typedef enum logic [3:0] {
        MEM_X         = 4'd0,
        MEM_LB        = 4'd1,
        MEM_LBU       = 4'd2,
        MEM_LH        = 4'd3,
        MEM_LHU       = 4'd4,
        MEM_LW        = 4'd5,
        MEM_SB        = 4'd6,
        MEM_SH        = 4'd7,
        MEM_SW        = 4'd8,
        MEM_AMOSWAP_W = 4'd9
    } mem_op_e;

    // writeback value source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_CSR = 2'd2
    } wb_sel_e;

    // **************************************************
    // pipeline records
    // **************************************************

    typedef struct packed {
        mem_op_e     mem_op;
        wb_sel_e     wb_sel;
        logic        rd_wen;
        logic [31:0] rs2_data;
    } ctrl_t;

    // record handed over by the execute stage
    typedef struct packed {
        logic [31:0] reg_pc;
        logic [63:0] inst_id;
        ctrl_t       ctrl;
        logic [31:0] alu_out;
        logic [31:0] csr_rdata;
    } mem_in_t;

    // record handed to writeback
    typedef struct packed {
        logic [31:0] reg_pc;
        logic [63:0] inst_id;
        logic        rd_wen;
        logic [31:0] wb_data;
    } wb_out_t;

    // data word, seen whole or as byte / halfword lanes
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } data_word_u;

    // **************************************************
    // memory geometry and timing
    // **************************************************

    // cycles from accepted command to completion
    localparam int MEM_LATENCY = 2;
    localparam int MEM_LAT_W = $clog2(MEM_LATENCY + 1);

    // depth in words
    localparam int MEM_DEPTH_LOG2 = 8;
    localparam int MEM_DEPTH = 1 << MEM_DEPTH_LOG2;

    // never carried by a real instruction
    localparam logic [63:0] INST_ID_NONE = 64'hffff_0000_0000_0000;

endpackage

// File: hw/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cmd_start,
    input  logic                 cmd_write,
    input  logic [31:0]          addr,
    input  core_pkg::data_word_u wdata,
    input  logic [3:0]           wmask,
    output logic                 cmd_ready,
    output logic                 rd_valid,
    output core_pkg::data_word_u rdata
);
    import core_pkg::*;

    data_word_u                mem_array [MEM_DEPTH];
    data_word_u                merged;
    logic [MEM_DEPTH_LOG2-1:0] word_idx;
    logic [MEM_LAT_W-1:0]      lat_cnt;
    logic                      rd_pend;
    logic                      accept;
    logic                      accept_rd;

    // **************************************************
    // handshake and latency
    // **************************************************

    assign accept    = cmd_start && cmd_ready;
    assign accept_rd = accept && !cmd_write;

    // word address, byte offset is ignored
    assign word_idx = addr[MEM_DEPTH_LOG2+1:2];

    // busy while the counter runs
    assign cmd_ready = (lat_cnt == '0);
    assign rd_valid  = rd_pend && (lat_cnt == MEM_LAT_W'(1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lat_cnt <= '0;
            rd_pend <= 1'b0;
        end else if (accept) begin
            lat_cnt <= MEM_LAT_W'(MEM_LATENCY);
            rd_pend <= !cmd_write;
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
            if (rd_valid) begin
                rd_pend <= 1'b0;
            end
        end
    end

    // **************************************************
    // storage
    // **************************************************

    // byte-masked merge with the current word
    always_comb begin
        merged = mem_array[word_idx];
        for (int i = 0; i < 4; i++) begin
            if (wmask[i]) begin
                merged.bytes[i] = wdata.bytes[i];
            end
        end
    end

    // write lands at the accepting edge, read word is held until rd_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            if (cmd_write) begin
                mem_array[word_idx] <= merged;
            end else begin
                rdata <= mem_array[word_idx];
            end
        end
    end

    // result comes exactly MEM_LATENCY cycles after the read was taken
    assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> $past(accept_rd, MEM_LATENCY));

endmodule

// File: hw/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 mem_valid,
    input  core_pkg::mem_in_t    mem_in,
    input  logic                 pipeline_flush,
    input  logic                 cmd_ready,
    input  logic                 rd_valid,
    input  core_pkg::data_word_u rdata,
    output logic                 cmd_start,
    output logic                 cmd_write,
    output logic [31:0]          addr,
    output core_pkg::data_word_u wdata,
    output logic [3:0]           wmask,
    output logic                 stall,
    output logic [31:0]          load_data
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_READY,
        S_WAIT_READ
    } state_e;

    state_e      state;
    mem_op_e     op_q;
    mem_op_e     cur_op;
    logic [63:0] done_id;
    data_word_u  load_q;
    logic        op_pending;
    logic        issue;
    logic        is_store;
    logic [1:0]  lane;

    // **************************************************
    // command side
    // **************************************************

    // held record still owes an access
    assign op_pending = mem_valid && (mem_in.ctrl.mem_op != MEM_X) &&
                        (mem_in.inst_id != done_id);

    // outside idle the registered op wins (swap turns into SW)
    assign cur_op   = (state == S_IDLE) ? mem_in.ctrl.mem_op : op_q;
    assign is_store = cur_op inside {MEM_SB, MEM_SH, MEM_SW};
    assign lane     = mem_in.alu_out[1:0];

    assign issue = mem_valid && !pipeline_flush &&
                   ((state == S_IDLE && op_pending) || state == S_WAIT_READY);

    assign cmd_start = issue && cmd_ready;
    assign cmd_write = is_store;
    assign addr      = mem_in.alu_out;

    // hold execute until the access has finished
    assign stall = mem_valid && ((state != S_IDLE) || op_pending);

    // store lane placement
    always_comb begin
        wdata.word = '0;
        wmask      = 4'b0000;
        case (cur_op)
            MEM_SB: begin
                wdata.bytes[lane] = mem_in.ctrl.rs2_data[7:0];
                wmask[lane]       = 1'b1;
            end
            MEM_SH: begin
                wdata.halves[lane[1]] = mem_in.ctrl.rs2_data[15:0];
                wmask                 = lane[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: begin
                wdata.word = mem_in.ctrl.rs2_data;
                wmask      = 4'b1111;
            end
            default: begin
                wmask = 4'b0000;
            end
        endcase
    end

    // **************************************************
    // sequencing
    // **************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            op_q    <= MEM_X;
            done_id <= INST_ID_NONE;
        end else if (pipeline_flush || !mem_valid) begin
            // any read still in flight is simply ignored
            state <= S_IDLE;
            op_q  <= MEM_X;
        end else begin
            case (state)
                S_IDLE: begin
                    if (op_pending) begin
                        op_q <= mem_in.ctrl.mem_op;
                        if (!cmd_ready) begin
                            state <= S_WAIT_READY;
                        end else if (is_store) begin
                            done_id <= mem_in.inst_id;
                        end else begin
                            state <= S_WAIT_READ;
                        end
                    end
                end
                S_WAIT_READY: begin
                    if (cmd_ready) begin
                        if (is_store) begin
                            state   <= S_IDLE;
                            op_q    <= MEM_X;
                            done_id <= mem_in.inst_id;
                        end else begin
                            state <= S_WAIT_READ;
                        end
                    end
                end
                S_WAIT_READ: begin
                    if (rd_valid) begin
                        if (op_q == MEM_AMOSWAP_W) begin
                            // second half of the swap
                            state <= S_WAIT_READY;
                            op_q  <= MEM_SW;
                        end else begin
                            state   <= S_IDLE;
                            op_q    <= MEM_X;
                            done_id <= mem_in.inst_id;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // read word, kept through the swap's store phase
    always_ff @(posedge clk) begin
        if (state == S_WAIT_READ && rd_valid) begin
            load_q <= rdata;
        end
    end

    // load lane select and extension
    always_comb begin
        case (mem_in.ctrl.mem_op)
            MEM_LB:  load_data = {{24{load_q.bytes[lane][7]}}, load_q.bytes[lane]};
            MEM_LBU: load_data = {24'h0, load_q.bytes[lane]};
            MEM_LH:  load_data = {{16{load_q.halves[lane[1]][15]}}, load_q.halves[lane[1]]};
            MEM_LHU: load_data = {16'h0, load_q.halves[lane[1]]};
            default: load_data = load_q.word;
        endcase
    end

    // misaligned accesses are not supported
    assert property (@(posedge clk) disable iff (!arst_n)
        cmd_start |->
            !((cur_op inside {MEM_LH, MEM_LHU, MEM_SH} && addr[0]) ||
              (cur_op inside {MEM_LW, MEM_SW, MEM_AMOSWAP_W} && addr[1:0] != 2'b00)));

endmodule

// File: hw/wb_select.sv
`timescale 1ns/1ps

module wb_select (
    input  logic              mem_valid,
    input  logic              stall,
    input  logic              pipeline_flush,
    input  core_pkg::mem_in_t mem_in,
    input  logic [31:0]       load_data,
    output logic              wb_valid,
    output core_pkg::wb_out_t wb_out
);
    import core_pkg::*;

    logic [31:0] wb_data;

    // value source
    always_comb begin
        case (mem_in.ctrl.wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_CSR:  wb_data = mem_in.csr_rdata;
            default: wb_data = mem_in.alu_out;
        endcase
    end

    // one pulse per instruction, on its last cycle
    assign wb_valid = mem_valid && !stall && !pipeline_flush;

    always_comb begin
        wb_out.reg_pc  = mem_in.reg_pc;
        wb_out.inst_id = mem_in.inst_id;
        wb_out.rd_wen  = mem_in.ctrl.rd_wen;
        wb_out.wb_data = wb_data;
    end

endmodule

// File: hw/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              mem_valid,
    input  core_pkg::mem_in_t mem_in,
    input  logic              pipeline_flush,
    output logic              stall,
    output logic              wb_valid,
    output core_pkg::wb_out_t wb_out
);
    import core_pkg::*;

    // **************************************************
    // controller to memory
    // **************************************************

    logic        cmd_start;
    logic        cmd_write;
    logic        cmd_ready;
    logic        rd_valid;
    logic [31:0] addr;
    logic [3:0]  wmask;
    data_word_u  wdata;
    data_word_u  rdata;

    // extended load value for writeback
    logic [31:0] load_data;

    mem_access_ctrl u_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_valid      (mem_valid),
        .mem_in         (mem_in),
        .pipeline_flush (pipeline_flush),
        .cmd_ready      (cmd_ready),
        .rd_valid       (rd_valid),
        .rdata          (rdata),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .addr           (addr),
        .wdata          (wdata),
        .wmask          (wmask),
        .stall          (stall),
        .load_data      (load_data)
    );

    data_mem u_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_start (cmd_start),
        .cmd_write (cmd_write),
        .addr      (addr),
        .wdata     (wdata),
        .wmask     (wmask),
        .cmd_ready (cmd_ready),
        .rd_valid  (rd_valid),
        .rdata     (rdata)
    );

    // alu and csr values bypass the controller
    wb_select u_wb (
        .mem_valid      (mem_valid),
        .stall          (stall),
        .pipeline_flush (pipeline_flush),
        .mem_in         (mem_in),
        .load_data      (load_data),
        .wb_valid       (wb_valid),
        .wb_out         (wb_out)
    );

endmodule

// File: include/mem_model.svh
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// **************************************************
// shadow of the 64-word test window
// **************************************************

// window is 256-byte aligned so addr[7:0] is the byte index
localparam logic [31:0] WIN_BASE = 32'h0000_0100;

logic [7:0] shadow [256];

function automatic logic [31:0] shadow_word(input logic [7:0] idx);
    logic [7:0] base;
    base = {idx[7:2], 2'b00};
    return {shadow[base + 8'd3], shadow[base + 8'd2], shadow[base + 8'd1], shadow[base]};
endfunction

// little endian, lowest byte at the lowest address
function automatic void put_bytes(input logic [7:0] idx, input logic [31:0] data,
                                  input int nbytes);
    for (int i = 0; i < nbytes; i++) begin
        shadow[idx + 8'(i)] = data[8*i +: 8];
    end
endfunction

// expected wb_data of a record, memory side effects applied at once
function automatic logic [31:0] expected_result(input mem_in_t rec);
    logic [7:0]  idx;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] ld;
    idx = rec.alu_out[7:0];
    b   = shadow[idx];
    h   = {shadow[idx + 8'd1], shadow[idx]};
    ld  = 32'h0;
    case (rec.ctrl.mem_op)
        MEM_LB:  ld = {{24{b[7]}}, b};
        MEM_LBU: ld = {24'h0, b};
        MEM_LH:  ld = {{16{h[15]}}, h};
        MEM_LHU: ld = {16'h0, h};
        MEM_LW:  ld = shadow_word(idx);
        MEM_SB:  put_bytes(idx, rec.ctrl.rs2_data, 1);
        MEM_SH:  put_bytes(idx, rec.ctrl.rs2_data, 2);
        MEM_SW:  put_bytes(idx, rec.ctrl.rs2_data, 4);
        MEM_AMOSWAP_W: begin
            // old word comes back, new word stays behind
            ld = shadow_word(idx);
            put_bytes(idx, rec.ctrl.rs2_data, 4);
        end
        default: ld = 32'h0;
    endcase
    case (rec.ctrl.wb_sel)
        WB_MEM:  return ld;
        WB_CSR:  return rec.csr_rdata;
        default: return rec.alu_out;
    endcase
endfunction

`endif

// File: test/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
    import core_pkg::*;

    localparam int NUM_INST = 400;
    localparam int TIMEOUT  = 50;

    logic    clk;
    logic    arst_n;
    logic    mem_valid;
    mem_in_t mem_in;
    logic    pipeline_flush;
    logic    stall;
    logic    wb_valid;
    wb_out_t wb_out;

    integer      seed;
    int          wb_count = 0;
    int          done_count;
    logic [63:0] next_id;

    `include "mem_model.svh"

    mem_subsys DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_valid      (mem_valid),
        .mem_in         (mem_in),
        .pipeline_flush (pipeline_flush),
        .stall          (stall),
        .wb_valid       (wb_valid),
        .wb_out         (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every writeback pulse, for the exactly-once count
    always @(posedge clk) begin
        if (wb_valid) begin
            wb_count <= wb_count + 1;
        end
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // random record for one op, aligned inside the window
    task automatic make_record(input mem_op_e op, output mem_in_t rec);
        logic [5:0] widx;
        logic [1:0] lane;
        widx = 6'($random(seed));
        lane = 2'($random(seed));
        if (op inside {MEM_LH, MEM_LHU, MEM_SH}) begin
            lane[0] = 1'b0;
        end else if (op inside {MEM_LW, MEM_SW, MEM_AMOSWAP_W}) begin
            lane = 2'b00;
        end
        rec                = '0;
        rec.reg_pc         = {$random(seed)} & 32'hffff_fffc;
        rec.inst_id        = next_id;
        rec.ctrl.mem_op    = op;
        rec.ctrl.rd_wen    = 1'($random(seed));
        rec.ctrl.rs2_data  = $random(seed);
        rec.alu_out        = WIN_BASE | {24'h0, widx, lane};
        rec.csr_rdata      = $random(seed);
        if (op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_AMOSWAP_W}) begin
            rec.ctrl.wb_sel = WB_MEM;
        end else if (op == MEM_X && $random(seed) % 2 != 0) begin
            rec.ctrl.wb_sel = WB_CSR;
        end else begin
            rec.ctrl.wb_sel = WB_ALU;
        end
        next_id = next_id + 64'd1;
    endtask

    // present a record and hold it until writeback or flush
    task automatic run_record(input mem_in_t rec, input logic flush_it, input int flush_at);
        logic [31:0] exp_data;
        int          cycles;
        logic        done;
        exp_data = expected_result(rec);
        cycles   = 0;
        done     = 1'b0;
        @(negedge clk);
        mem_valid      = 1'b1;
        mem_in         = rec;
        pipeline_flush = 1'b0;
        while (!done) begin
            if (flush_it && cycles == flush_at) begin
                pipeline_flush = 1'b1;
            end
            #1;
            if (pipeline_flush) begin
                check_value("stall", 64'(stall), 64'd1);
                check_value("wb_valid", 64'(wb_valid), 64'd0);
                @(negedge clk);
                mem_valid      = 1'b0;
                pipeline_flush = 1'b0;
                #1;
                check_value("stall", 64'(stall), 64'd0);
                check_value("wb_valid", 64'(wb_valid), 64'd0);
                done = 1'b1;
            end else if (wb_valid) begin
                check_value("stall", 64'(stall), 64'd0);
                if (rec.ctrl.mem_op == MEM_X) begin
                    check_value("stall_cycles", 64'(cycles), 64'd0);
                end else begin
                    check_value("access_done", 64'(cycles != 0), 64'd1);
                end
                check_value("wb_out.wb_data", 64'(wb_out.wb_data), 64'(exp_data));
                check_value("wb_out.inst_id", wb_out.inst_id, rec.inst_id);
                check_value("wb_out.reg_pc", 64'(wb_out.reg_pc), 64'(rec.reg_pc));
                check_value("wb_out.rd_wen", 64'(wb_out.rd_wen), 64'(rec.ctrl.rd_wen));
                done_count = done_count + 1;
                done       = 1'b1;
            end else begin
                cycles = cycles + 1;
                if (cycles > TIMEOUT) begin
                    $display("timeout: no writeback for inst_id %0d", rec.inst_id);
                    stop_run();
                end
                @(negedge clk);
            end
        end
    endtask

    initial begin
        mem_in_t rec;
        mem_in_t follow;
        mem_op_e op;
        logic    flush_it;
        int      flush_at;
        seed           = 32'h219f;
        next_id        = 64'd1;
        done_count     = 0;
        arst_n         = 1'b0;
        mem_valid      = 1'b0;
        mem_in         = '0;
        pipeline_flush = 1'b0;

        // **************************************************
        // reset
        // **************************************************
        repeat (3) begin
            @(negedge clk);
            check_value("stall", 64'(stall), 64'd0);
            check_value("wb_valid", 64'(wb_valid), 64'd0);
        end
        arst_n = 1'b1;
        @(negedge clk);
        #1;
        check_value("stall", 64'(stall), 64'd0);
        check_value("wb_valid", 64'(wb_valid), 64'd0);

        // fill the window so every later load has a known value
        for (int w = 0; w < 64; w++) begin
            make_record(MEM_SW, rec);
            rec.alu_out = WIN_BASE + 32'(w * 4);
            run_record(rec, 1'b0, 0);
        end

        // **************************************************
        // random instruction stream
        // **************************************************
        for (int n = 0; n < NUM_INST; n++) begin
            op = mem_op_e'({$random(seed)} % 10);
            make_record(op, rec);
            flush_it = (op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW}) &&
                       ({$random(seed)} % 8 == 0);
            flush_at = {$random(seed)} % 3;
            run_record(rec, flush_it, flush_at);
            // a swap is read back at once
            if (op == MEM_AMOSWAP_W) begin
                make_record(MEM_LW, follow);
                follow.alu_out = rec.alu_out;
                run_record(follow, 1'b0, 0);
            end
            if ({$random(seed)} % 16 == 0) begin
                @(negedge clk);
                mem_valid = 1'b0;
                #1;
                check_value("wb_valid", 64'(wb_valid), 64'd0);
            end
        end

        @(negedge clk);
        mem_valid = 1'b0;
        @(negedge clk);
        if (wb_count == done_count) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("writeback count %0d differs from completed count %0d",
                     wb_count, done_count);
            stop_run();
        end
    end

endmodule

// File: files.f
+incdir+include
hw/core_pkg.sv
hw/data_mem.sv
hw/mem_access_ctrl.sv
hw/wb_select.sv
hw/mem_subsys.sv
test/tb_mem_subsys.sv

// File: Makefile
# Verilator build and run for the memory-access stage
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) include/mem_model.svh
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator status is ignored, the log decides
run: compile
	-./$(EXE) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
